// ==== hdl/ac97_pkg.sv ====
`default_nettype none

////////////////////////////////////////
// ac97 link constants
////////////////////////////////////////

package ac97_pkg;

  // sample and slot widths
  localparam int sample_width = 18;
  localparam int slot_width = 20;
  localparam int volume_width = 5;
  localparam int cmd_addr_width = 8;
  localparam int cmd_data_width = 16;

  // frame geometry, in bit clocks from the start of slot 0
  localparam int frame_bits = 256;
  localparam int sync_end_bit = 15;
  localparam int ready_set_bit = 128;
  localparam int ready_clear_bit = 2;
  localparam int slot1_first_bit = 16;
  localparam int slot2_first_bit = 36;
  localparam int slot3_first_bit = 56;
  localparam int slot4_first_bit = 76;
  localparam int slots_end_bit = 96;
  // input bits arrive half a bit late, so capture on the next falling edge
  localparam int capture_first_bit = 57;

  ////////////////////////////////////////
  // codec register addresses
  ////////////////////////////////////////

  // bit 7 set makes this a read
  localparam logic [cmd_addr_width-1:0] reg_reset_id = 8'h80;
  localparam logic [cmd_addr_width-1:0] reg_headphone_vol = 8'h04;
  localparam logic [cmd_addr_width-1:0] reg_pcm_vol = 8'h18;
  localparam logic [cmd_addr_width-1:0] reg_record_select = 8'h1A;
  localparam logic [cmd_addr_width-1:0] reg_record_gain = 8'h1C;
  localparam logic [cmd_addr_width-1:0] reg_mic_gain = 8'h0E;
  localparam logic [cmd_addr_width-1:0] reg_beep_vol = 8'h0A;
  localparam logic [cmd_addr_width-1:0] reg_general = 8'h20;

  // fixed register values
  localparam logic [cmd_data_width-1:0] pcm_vol_value = 16'h0808;
  // record gain at max
  localparam logic [cmd_data_width-1:0] record_gain_value = 16'h0F0F;
  // +20 dB mic boost
  localparam logic [cmd_data_width-1:0] mic_gain_value = 16'h8048;
  localparam logic [cmd_data_width-1:0] beep_vol_value = 16'h0000;
  // pcm out bypasses mix1
  localparam logic [cmd_data_width-1:0] general_value = 16'h8000;

  ////////////////////////////////////////
  // misc
  ////////////////////////////////////////

  // record source selector, 0 is the microphone
  localparam logic [2:0] record_source_mic = 3'd0;

  localparam logic [volume_width-1:0] max_volume = 5'd31;
  localparam logic [volume_width-1:0] reset_volume = 5'd8;

  // system clocks held in codec reset
  localparam int codec_reset_cycles = 1024;
  // 10 ms at 27 MHz
  localparam int debounce_cycles_default = 270000;

endpackage

`default_nettype wire

// ==== hdl/debounce.sv ====
`default_nettype none
`timescale 1ns/1ns

// level debouncer for a push button or switch
module debounce #(
  parameter int stable_cycles = 270000
) (
  input  logic clock,
  input  logic reset,
  input  logic noisy,
  output logic clean
);

  // copy of the last level seen on noisy
  logic held;
  logic [$clog2(stable_cycles+1)-1:0] count;

  always_ff @(posedge clock) begin
    if (reset) begin
      // start out already settled on the current level
      held <= noisy;
      clean <= noisy;
      count <= '0;
    end else if (noisy != held) begin
      // bounce or real change, start the wait again
      held <= noisy;
      count <= '0;
    end else if (count == stable_cycles) begin
      // stable long enough, pass it on
      clean <= held;
    end else begin
      count <= count + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/volume_control.sv ====
`default_nettype none
`timescale 1ns/1ns

// up/down buttons stepping a saturating volume
module volume_control #(
  parameter int debounce_cycles = 270000
) (
  input  logic clock,
  input  logic reset,
  input  logic volume_up,
  input  logic volume_down,
  output logic [ac97_pkg::volume_width-1:0] volume
);

  logic up_clean;
  logic down_clean;
  // debounced levels from the previous cycle
  logic up_prev;
  logic down_prev;
  logic up_edge;
  logic down_edge;

  debounce #(.stable_cycles(debounce_cycles)) i_debounce_up (
    .clock(clock),
    .reset(reset),
    .noisy(volume_up),
    .clean(up_clean)
  );

  debounce #(.stable_cycles(debounce_cycles)) i_debounce_down (
    .clock(clock),
    .reset(reset),
    .noisy(volume_down),
    .clean(down_clean)
  );

  // one step per press, on the press and not the release
  assign up_edge = up_clean & ~up_prev;
  assign down_edge = down_clean & ~down_prev;

  always_ff @(posedge clock) begin
    if (reset) begin
      volume <= ac97_pkg::reset_volume;
      // a button held through reset is not a press
      up_prev <= up_clean;
      down_prev <= down_clean;
    end else begin
      up_prev <= up_clean;
      down_prev <= down_clean;
      if (up_edge && volume != ac97_pkg::max_volume) begin
        volume <= volume + 1'b1;
      end
      // down is written last, so it wins a tie
      if (down_edge && volume != '0) begin
        volume <= volume - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/ac97_commands.sv ====
`default_nettype none
`timescale 1ns/1ns

// repeating list of codec register accesses, one per frame
module ac97_commands (
  input  logic clock,
  input  logic reset,
  input  logic ready,
  input  logic [ac97_pkg::volume_width-1:0] volume,
  output logic [ac97_pkg::cmd_addr_width-1:0] cmd_address,
  output logic [ac97_pkg::cmd_data_width-1:0] cmd_data,
  output logic cmd_valid
);

  logic [3:0] step;
  // step after this clock, so the word follows ready by one clock
  logic [3:0] step_next;
  // headphone attenuation, 0 is loudest
  logic [ac97_pkg::volume_width-1:0] atten;

  assign step_next = ready ? step + 1'b1 : step;
  assign atten = ac97_pkg::max_volume - volume;

  always_ff @(posedge clock) begin
    if (reset) begin
      step <= '0;
      cmd_valid <= 1'b0;
      cmd_address <= ac97_pkg::reg_reset_id;
      cmd_data <= '0;
    end else begin
      step <= step_next;
      cmd_valid <= 1'b1;
      case (step_next)
        4'd3: begin
          // same attenuation for left and right
          cmd_address <= ac97_pkg::reg_headphone_vol;
          cmd_data <= {3'b000, atten, 3'b000, atten};
        end
        4'd5: begin
          cmd_address <= ac97_pkg::reg_pcm_vol;
          cmd_data <= ac97_pkg::pcm_vol_value;
        end
        4'd6: begin
          cmd_address <= ac97_pkg::reg_record_select;
          cmd_data <= {5'b00000, ac97_pkg::record_source_mic,
                       5'b00000, ac97_pkg::record_source_mic};
        end
        4'd7: begin
          cmd_address <= ac97_pkg::reg_record_gain;
          cmd_data <= ac97_pkg::record_gain_value;
        end
        4'd9: begin
          cmd_address <= ac97_pkg::reg_mic_gain;
          cmd_data <= ac97_pkg::mic_gain_value;
        end
        4'd10: begin
          cmd_address <= ac97_pkg::reg_beep_vol;
          cmd_data <= ac97_pkg::beep_vol_value;
        end
        4'd11: begin
          cmd_address <= ac97_pkg::reg_general;
          cmd_data <= ac97_pkg::general_value;
        end
        default: begin
          // idle steps read the vendor id
          cmd_address <= ac97_pkg::reg_reset_id;
          cmd_data <= '0;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== hdl/ac97_frame.sv ====
`default_nettype none
`timescale 1ns/1ns

// ac97 frame builder and slot 3 capture, all on the codec bit clock
module ac97_frame (
  input  logic reset,
  input  logic ac97_bit_clock,
  input  logic [ac97_pkg::cmd_addr_width-1:0] cmd_address,
  input  logic [ac97_pkg::cmd_data_width-1:0] cmd_data,
  input  logic cmd_valid,
  input  logic [ac97_pkg::slot_width-1:0] sample_out,
  input  logic ac97_sdata_in,
  output logic frame_ready,
  output logic [ac97_pkg::slot_width-1:0] sample_in,
  output logic ac97_sdata_out,
  output logic ac97_synch
);

  // reset brought over to the bit clock
  logic [1:0] reset_sync;
  logic frame_reset;
  logic [$clog2(ac97_pkg::frame_bits)-1:0] bit_count;

  // per-frame copies of the system side, left justified
  logic [ac97_pkg::slot_width-1:0] l_cmd_addr;
  logic [ac97_pkg::slot_width-1:0] l_cmd_data;
  logic [ac97_pkg::slot_width-1:0] l_sample;
  logic l_cmd_valid;
  logic l_sample_valid;

  always_ff @(posedge ac97_bit_clock) begin
    reset_sync <= {reset_sync[0], reset};
  end

  assign frame_reset = reset_sync[1];

  ////////////////////////////////////////
  // counter, sync, ready, latches
  ////////////////////////////////////////

  always_ff @(posedge ac97_bit_clock) begin
    if (frame_reset) begin
      bit_count <= '0;
      ac97_synch <= 1'b0;
      frame_ready <= 1'b0;
      l_cmd_valid <= 1'b0;
      l_sample_valid <= 1'b0;
    end else begin
      // wraps from 255 back to 0
      bit_count <= bit_count + 1'b1;

      // sync covers slot 0, rising just before bit 0
      if (bit_count == ac97_pkg::frame_bits - 1) begin
        ac97_synch <= 1'b1;
      end else if (bit_count == ac97_pkg::sync_end_bit) begin
        ac97_synch <= 1'b0;
      end

      // ready spans the idle half of the frame into the next one
      if (bit_count == ac97_pkg::ready_set_bit) begin
        frame_ready <= 1'b1;
      end else if (bit_count == ac97_pkg::ready_clear_bit) begin
        frame_ready <= 1'b0;
      end

      // take new data at the frame boundary, first frame goes out empty
      if (bit_count == ac97_pkg::frame_bits - 1) begin
        l_cmd_addr <= {cmd_address,
                       {(ac97_pkg::slot_width - ac97_pkg::cmd_addr_width){1'b0}}};
        l_cmd_data <= {cmd_data,
                       {(ac97_pkg::slot_width - ac97_pkg::cmd_data_width){1'b0}}};
        l_cmd_valid <= cmd_valid;
        l_sample <= sample_out;
        l_sample_valid <= 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // serial output
  ////////////////////////////////////////

  always_ff @(posedge ac97_bit_clock) begin
    if (frame_reset) begin
      ac97_sdata_out <= 1'b0;
    end else if (bit_count < ac97_pkg::slot1_first_bit) begin
      // slot 0 tag bits
      case (bit_count[3:0])
        4'd0: ac97_sdata_out <= 1'b1;
        4'd1: ac97_sdata_out <= l_cmd_valid;
        4'd2: ac97_sdata_out <= l_cmd_valid;
        4'd3: ac97_sdata_out <= l_sample_valid;
        4'd4: ac97_sdata_out <= l_sample_valid;
        default: ac97_sdata_out <= 1'b0;
      endcase
    end else if (bit_count < ac97_pkg::slot2_first_bit) begin
      // slot 1, command address
      ac97_sdata_out <= l_cmd_valid &
                        l_cmd_addr[ac97_pkg::slot2_first_bit - 1 - bit_count];
    end else if (bit_count < ac97_pkg::slot3_first_bit) begin
      // slot 2, command data
      ac97_sdata_out <= l_cmd_valid &
                        l_cmd_data[ac97_pkg::slot3_first_bit - 1 - bit_count];
    end else if (bit_count < ac97_pkg::slot4_first_bit) begin
      // slot 3, left
      ac97_sdata_out <= l_sample_valid &
                        l_sample[ac97_pkg::slot4_first_bit - 1 - bit_count];
    end else if (bit_count < ac97_pkg::slots_end_bit) begin
      // slot 4, right gets the same sample
      ac97_sdata_out <= l_sample_valid &
                        l_sample[ac97_pkg::slots_end_bit - 1 - bit_count];
    end else begin
      ac97_sdata_out <= 1'b0;
    end
  end

  // left capture, MSB first, on falling edges
  always_ff @(negedge ac97_bit_clock) begin
    if (frame_reset) begin
      sample_in <= '0;
    end else if (bit_count >= ac97_pkg::capture_first_bit &&
                 bit_count < ac97_pkg::capture_first_bit + ac97_pkg::slot_width) begin
      sample_in <= {sample_in[ac97_pkg::slot_width-2:0], ac97_sdata_in};
    end
  end

endmodule

`default_nettype wire

// ==== hdl/ac97_audio.sv ====
`default_nettype none
`timescale 1ns/1ns

// mono ac97 link with volume buttons
module ac97_audio #(
  parameter int debounce_cycles = ac97_pkg::debounce_cycles_default
) (
  input  logic clock,
  input  logic reset,
  input  logic volume_up,
  input  logic volume_down,
  input  logic [ac97_pkg::sample_width-1:0] audio_out_data,
  input  logic ac97_bit_clock,
  input  logic ac97_sdata_in,
  output logic [ac97_pkg::sample_width-1:0] audio_in_data,
  output logic ready,
  output logic [ac97_pkg::volume_width-1:0] volume,
  output logic audio_reset_b,
  output logic ac97_sdata_out,
  output logic ac97_synch
);

  logic [$clog2(ac97_pkg::codec_reset_cycles)-1:0] reset_count;
  logic frame_ready;
  // two flops of synchronizer, then the edge detector's history bit
  logic [1:0] ready_sync;
  logic ready_prev;
  logic [ac97_pkg::sample_width-1:0] out_sample;
  logic [ac97_pkg::slot_width-1:0] slot_out;
  logic [ac97_pkg::slot_width-1:0] slot_in;
  logic [ac97_pkg::cmd_addr_width-1:0] cmd_address;
  logic [ac97_pkg::cmd_data_width-1:0] cmd_data;
  logic cmd_valid;

  ////////////////////////////////////////
  // codec reset delay
  ////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      reset_count <= '0;
      audio_reset_b <= 1'b0;
    end else if (reset_count == ac97_pkg::codec_reset_cycles - 1) begin
      audio_reset_b <= 1'b1;
    end else begin
      reset_count <= reset_count + 1'b1;
    end
  end

  // frame_ready into the system clock, one pulse per frame
  always_ff @(posedge clock) begin
    if (reset) begin
      ready_sync <= '0;
      ready_prev <= 1'b0;
      ready <= 1'b0;
    end else begin
      ready_sync <= {ready_sync[0], frame_ready};
      ready_prev <= ready_sync[1];
      ready <= ready_sync[1] & ~ready_prev;
    end
  end

  // playback sample, held until the next strobe
  always_ff @(posedge clock) begin
    if (reset) begin
      out_sample <= '0;
    end else if (ready) begin
      out_sample <= audio_out_data;
    end
  end

  // 18 bit samples sit in the top of the 20 bit slot
  assign slot_out = {out_sample, 2'b00};
  assign audio_in_data = slot_in[ac97_pkg::slot_width-1 -: ac97_pkg::sample_width];

  volume_control #(.debounce_cycles(debounce_cycles)) i_volume_control (
    .clock(clock),
    .reset(reset),
    .volume_up(volume_up),
    .volume_down(volume_down),
    .volume(volume)
  );

  ac97_commands i_ac97_commands (
    .clock(clock),
    .reset(reset),
    .ready(ready),
    .volume(volume),
    .cmd_address(cmd_address),
    .cmd_data(cmd_data),
    .cmd_valid(cmd_valid)
  );

  ac97_frame i_ac97_frame (
    .reset(reset),
    .ac97_bit_clock(ac97_bit_clock),
    .cmd_address(cmd_address),
    .cmd_data(cmd_data),
    .cmd_valid(cmd_valid),
    .sample_out(slot_out),
    .ac97_sdata_in(ac97_sdata_in),
    .frame_ready(frame_ready),
    .sample_in(slot_in),
    .ac97_sdata_out(ac97_sdata_out),
    .ac97_synch(ac97_synch)
  );

endmodule

`default_nettype wire

// ==== test/ac97_audio_checker.sv ====
`default_nettype none
`timescale 1ns/1ns

// timing rules of the ac97 link, bound into ac97_audio
module ac97_audio_checker (
  input logic clock,
  input logic reset,
  input logic ready,
  input logic audio_reset_b,
  input logic ac97_bit_clock,
  input logic frame_reset,
  input logic [7:0] bit_count,
  input logic ac97_synch,
  input logic ac97_sdata_out
);

  // failed assertions, read by the testbench at the end of the run
  int failure_count;

  initial failure_count = 0;

  ////////////////////////////////////////
  // bit clock side
  ////////////////////////////////////////

  // sync covers exactly slot 0
  property synch_width;
    @(posedge ac97_bit_clock) disable iff (frame_reset)
      $rose(ac97_synch) |-> ac97_synch [*16] ##1 !ac97_synch;
  endproperty

  // output lags the count by one bit, so count 0 still shows the last idle bit
  property idle_slots_quiet;
    @(posedge ac97_bit_clock) disable iff (frame_reset)
      (bit_count > ac97_pkg::slots_end_bit || bit_count == 0) |-> !ac97_sdata_out;
  endproperty

  ////////////////////////////////////////
  // system clock side
  ////////////////////////////////////////

  property ready_single;
    @(posedge clock) disable iff (reset)
      ready |=> !ready;
  endproperty

  // codec reset is released once and stays released
  property codec_reset_held;
    @(posedge clock) disable iff (reset)
      audio_reset_b |=> audio_reset_b;
  endproperty

  assert property (synch_width) else begin
    $error("ac97_synch was not high for exactly 16 bit clocks");
    failure_count++;
  end

  assert property (idle_slots_quiet) else begin
    $error("ac97_sdata_out was high in the unused slots");
    failure_count++;
  end

  assert property (ready_single) else begin
    $error("ready stayed high for two clock cycles");
    failure_count++;
  end

  assert property (codec_reset_held) else begin
    $error("audio_reset_b fell after it was released");
    failure_count++;
  end

endmodule

`default_nettype wire

// ==== test/ac97_audio_tb.sv ====
`default_nettype none
`timescale 1ns/1ns

module ac97_audio_tb;

  localparam int clock_period = 8;
  localparam int bit_clock_period = 80;
  localparam int test_debounce = 20;
  localparam int frame_time = ac97_pkg::frame_bits * bit_clock_period;
  // the tests need about 55 frames, plus the codec reset delay at the start
  localparam int watchdog_time =
    60 * frame_time + ac97_pkg::codec_reset_cycles * clock_period;

  logic clock;
  logic reset;
  logic volume_up;
  logic volume_down;
  logic [17:0] audio_out_data;
  logic ac97_bit_clock;
  logic ac97_sdata_in;
  logic [17:0] audio_in_data;
  logic ready;
  logic [4:0] volume;
  logic audio_reset_b;
  logic ac97_sdata_out;
  logic ac97_synch;

  int error_count;
  int check_count;
  logic [31:0] lcg_state;
  // volume the buttons should have produced
  logic [4:0] expected_volume;

  // strobe counter and its value at the last sync rise
  int ready_pulses;
  int pulses_at_sync;

  // codec side view of the last frame, bit 95 is the first bit sent
  logic [95:0] rx_bits;
  logic [4:0] rx_tags;
  logic [19:0] rx_slot1;
  logic [19:0] rx_slot2;
  logic [7:0] rx_address;
  logic [15:0] rx_data;
  logic [19:0] rx_left;
  logic [19:0] rx_right;

  ac97_audio #(.debounce_cycles(test_debounce)) i_dut (
    .clock(clock),
    .reset(reset),
    .volume_up(volume_up),
    .volume_down(volume_down),
    .audio_out_data(audio_out_data),
    .ac97_bit_clock(ac97_bit_clock),
    .ac97_sdata_in(ac97_sdata_in),
    .audio_in_data(audio_in_data),
    .ready(ready),
    .volume(volume),
    .audio_reset_b(audio_reset_b),
    .ac97_sdata_out(ac97_sdata_out),
    .ac97_synch(ac97_synch)
  );

  bind ac97_audio ac97_audio_checker i_checker (
    .clock(clock),
    .reset(reset),
    .ready(ready),
    .audio_reset_b(audio_reset_b),
    .ac97_bit_clock(ac97_bit_clock),
    .frame_reset(i_ac97_frame.frame_reset),
    .bit_count(i_ac97_frame.bit_count),
    .ac97_synch(ac97_synch),
    .ac97_sdata_out(ac97_sdata_out)
  );

  always #(clock_period / 2) clock = ~clock;

  // codec bit clock, unrelated to the system clock
  always #(bit_clock_period / 2) ac97_bit_clock = ~ac97_bit_clock;

  // ready is one clock wide, so one falling edge sees each pulse
  always @(negedge clock) begin
    if (ready === 1'b1) begin
      ready_pulses++;
    end
  end

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic expect_true(input logic ok, input string what);
    check_count++;
    assert (ok === 1'b1) else begin
      error_count++;
      $display("CHECK FAILED at %0t ns: %s", $time, what);
    end
  endtask

  // register and data pairs the codec may be sent, straight from the command table
  function automatic logic command_ok(input logic [7:0] address,
                                      input logic [15:0] data,
                                      input logic [4:0] vol);
    logic [4:0] atten;
    atten = 5'd31 - vol;
    case (address)
      8'h04: command_ok = (data == {3'b000, atten, 3'b000, atten});
      8'h18: command_ok = (data == 16'h0808);
      8'h1A: command_ok = (data == 16'h0000);
      8'h1C: command_ok = (data == 16'h0F0F);
      8'h0E: command_ok = (data == 16'h8048);
      8'h0A: command_ok = (data == 16'h0000);
      8'h20: command_ok = (data == 16'h8000);
      8'h80: command_ok = (data == 16'h0000);
      default: command_ok = 1'b0;
    endcase
  endfunction

  function automatic int command_index(input logic [7:0] address);
    case (address)
      8'h04: command_index = 0;
      8'h18: command_index = 1;
      8'h1A: command_index = 2;
      8'h1C: command_index = 3;
      8'h0E: command_index = 4;
      8'h0A: command_index = 5;
      8'h20: command_index = 6;
      default: command_index = 7;
    endcase
  endfunction

  // codec model, samples slots 0 to 4 of the next frame on falling bit clocks
  task automatic read_frame();
    int i;
    @(posedge ac97_synch);
    pulses_at_sync = ready_pulses;
    // first data bit goes out one bit clock after sync rises
    @(posedge ac97_bit_clock);
    for (i = 0; i < 96; i++) begin
      @(negedge ac97_bit_clock);
      rx_bits[95 - i] = ac97_sdata_out;
    end
    rx_tags = rx_bits[95:91];
    rx_slot1 = rx_bits[79:60];
    rx_slot2 = rx_bits[59:40];
    rx_address = rx_slot1[19:12];
    rx_data = rx_slot2[19:4];
    rx_left = rx_bits[39:20];
    rx_right = rx_bits[19:0];
  endtask

  task automatic press_button(input logic up, input int hold);
    @(negedge clock);
    if (up) begin
      volume_up = 1'b1;
    end else begin
      volume_down = 1'b1;
    end
    repeat (hold) @(negedge clock);
    volume_up = 1'b0;
    volume_down = 1'b0;
  endtask

  // a full press and release, then the volume against the model
  task automatic step_volume(input logic up);
    press_button(up, test_debounce + 8);
    repeat (test_debounce + 8) @(negedge clock);
    if (up && expected_volume != 5'd31) begin
      expected_volume = expected_volume + 1'b1;
    end else if (!up && expected_volume != 5'd0) begin
      expected_volume = expected_volume - 1'b1;
    end
    expect_true(volume == expected_volume,
                $sformatf("volume %0d, expected %0d", volume, expected_volume));
  endtask

  ////////////////////////////////////////
  // tests
  ////////////////////////////////////////

  task automatic test_reset();
    int n;
    repeat (9) @(negedge clock);
    expect_true(ready == 1'b0, "ready high during reset");
    expect_true(audio_reset_b == 1'b0, "audio_reset_b high during reset");
    expect_true(volume == 5'd8, $sformatf("volume %0d after reset, expected 8", volume));
    @(negedge clock);
    reset = 1'b0;
    n = 0;
    while (audio_reset_b !== 1'b1 && n < 2048) begin
      @(negedge clock);
      n++;
      // frame side has left its own reset by now, first frame not done yet
      if (n >= 50 && audio_reset_b !== 1'b1) begin
        expect_true(ac97_synch == 1'b0, "ac97_synch high during the codec reset delay");
        expect_true(ready == 1'b0, "ready high during the codec reset delay");
      end
    end
    expect_true(n == 1024, $sformatf("audio_reset_b rose after %0d clocks, expected 1024", n));
  endtask

  task automatic test_strobe_rate();
    int k;
    int last_pulses;
    read_frame();
    last_pulses = pulses_at_sync;
    for (k = 0; k < 10; k++) begin
      read_frame();
      expect_true(pulses_at_sync - last_pulses == 1,
                  $sformatf("%0d ready pulses in frame %0d", pulses_at_sync - last_pulses, k));
      expect_true(rx_tags[4] == 1'b1, "frame valid tag clear");
      last_pulses = pulses_at_sync;
    end
  endtask

  task automatic test_commands();
    int k;
    logic [7:0] seen;
    seen = '0;
    for (k = 0; k < 18; k++) begin
      read_frame();
      expect_true(rx_tags[3:2] == 2'b11, "command valid tags clear");
      expect_true(command_ok(rx_address, rx_data, expected_volume),
                  $sformatf("command %02h data %04h not in the table", rx_address, rx_data));
      expect_true(rx_slot1[11:0] == '0 && rx_slot2[3:0] == '0,
                  "padding bits of slot 1 or 2 not zero");
      seen[command_index(rx_address)] = 1'b1;
    end
    expect_true(seen == 8'hFF, $sformatf("registers seen %08b, expected all", seen));
  endtask

  task automatic test_playback();
    logic [31:0] r;
    logic [17:0] value;
    r = next_random();
    value = r[17:0];
    @(negedge clock);
    audio_out_data = value;
    // latched on the next strobe, sent from the frame after it
    repeat (3) read_frame();
    expect_true(rx_tags[1:0] == 2'b11, "sample valid tags clear");
    expect_true(rx_left == {value, 2'b00},
                $sformatf("slot 3 %05h, expected %05h", rx_left, {value, 2'b00}));
    expect_true(rx_right == {value, 2'b00},
                $sformatf("slot 4 %05h, expected %05h", rx_right, {value, 2'b00}));
  endtask

  task automatic test_capture();
    logic [31:0] r;
    logic [19:0] word;
    int c;
    r = next_random();
    word = r[19:0];
    @(posedge ac97_synch);
    // slot 3 bits, MSB first, ahead of the falling edges that take them
    for (c = 1; c <= 77; c++) begin
      @(posedge ac97_bit_clock);
      if (c >= ac97_pkg::capture_first_bit && c < ac97_pkg::capture_first_bit + 20) begin
        ac97_sdata_in = word[ac97_pkg::capture_first_bit + 19 - c];
      end else begin
        ac97_sdata_in = 1'b0;
      end
    end
    repeat (2) @(negedge ac97_bit_clock);
    expect_true(audio_in_data == word[19:2],
                $sformatf("audio_in_data %05h, expected %05h", audio_in_data, word[19:2]));
  endtask

  task automatic test_volume();
    int k;
    int frames;
    logic [31:0] r;
    logic found;
    logic [4:0] atten;
    // glitches shorter than the debounce time
    for (k = 0; k < 5; k++) begin
      r = next_random();
      press_button(1'b1, 1 + r % (test_debounce - 2));
      repeat (3) @(negedge clock);
    end
    repeat (2 * test_debounce) @(negedge clock);
    expect_true(volume == expected_volume, "short volume_up pulses changed volume");
    // up past the top, then down past the bottom
    for (k = 0; k < 26; k++) begin
      step_volume(1'b1);
    end
    for (k = 0; k < 34; k++) begin
      step_volume(1'b0);
    end
    // the next frame may hold a command built before the last press
    read_frame();
    found = 1'b0;
    frames = 0;
    while (!found && frames < 16) begin
      read_frame();
      frames++;
      found = (rx_address == 8'h04);
    end
    assert (found) else begin
      error_count++;
      $display("no headphone volume command seen within 16 frames");
    end
    atten = 5'd31 - expected_volume;
    if (found) begin
      expect_true(rx_data == {3'b000, atten, 3'b000, atten},
                  $sformatf("headphone data %04h, attenuation %0d", rx_data, atten));
    end
  endtask

  ////////////////////////////////////////
  // run
  ////////////////////////////////////////

  initial begin
    clock = 1'b0;
    ac97_bit_clock = 1'b0;
    reset = 1'b1;
    volume_up = 1'b0;
    volume_down = 1'b0;
    audio_out_data = '0;
    ac97_sdata_in = 1'b0;
    error_count = 0;
    check_count = 0;
    ready_pulses = 0;
    pulses_at_sync = 0;
    lcg_state = 32'h9184f35c;
    expected_volume = 5'd8;

    test_reset();
    test_strobe_rate();
    test_commands();
    test_playback();
    test_capture();
    test_volume();

    $display("checks %0d, errors %0d, assertion failures %0d",
             check_count, error_count, i_dut.i_checker.failure_count);
    if (error_count == 0 && i_dut.i_checker.failure_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // stops a run that hangs waiting on the link
  initial begin
    #(watchdog_time);
    $display("timeout after %0d ns, tests did not finish", watchdog_time);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
hdl/ac97_pkg.sv
hdl/debounce.sv
hdl/volume_control.sv
hdl/ac97_commands.sv
hdl/ac97_frame.sv
hdl/ac97_audio.sv
test/ac97_audio_checker.sv
test/ac97_audio_tb.sv

// ==== Bender.yml ====
package:
  name: ac97_audio

sources:
  - files:
      - hdl/ac97_pkg.sv
      - hdl/debounce.sv
      - hdl/volume_control.sv
      - hdl/ac97_commands.sv
      - hdl/ac97_frame.sv
      - hdl/ac97_audio.sv
  - target: test
    files:
      - test/ac97_audio_checker.sv
      - test/ac97_audio_tb.sv
